/* all.f */
src/fftPkg.sv
src/hostPkg.sv
src/twiddleRom.sv
src/butterflyUnit.sv
src/addressGen.sv
src/fftRam.sv
src/sampleBuffers.sv
src/fftControl.sv
src/fftAccel.sv
tb/fftAccelTb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench, pass only if the log holds the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
        --top-module fftAccelTb -o fftAccelTb \
    && ./obj_dir/fftAccelTb > sim.log \
    ; cat sim.log 2>/dev/null \
    ; grep -q "All checks passed" sim.log \
    || { echo "simulation failed"; exit 1; }

echo "simulation passed"

/* tb/fftAccelTb.sv */
module fftAccelTb
    import fftPkg::*;
    import hostPkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int JOB_COUNT       = 6;
    // worst case per job is a slow load, a full compute and an unload at one grant in four
    localparam int JOB_CYCLE_BOUND = 2 * FFT_POINTS + FFT_STAGES * BFLY_PER_STAGE
                                     + 16 * FFT_POINTS;
    localparam int TIMEOUT_CYCLES  = 2 * JOB_COUNT * JOB_CYCLE_BOUND + 160;

    logic     clk = 1'b0;
    logic     rst;
    logic     start;
    logic     inverse;
    tagT      tag;
    logic     inValid;
    cplxWordT inData;
    logic     outCredit;
    logic     inCreditReturn;
    logic     outValid;
    cplxWordT outData;
    tagT      outTag;
    logic     busy;
    logic     done;

    cplxWordT    inQueue[$];                            // words waiting for an input credit
    cplxWordT    rxQueue[$];                            // words received this job
    cplxWordT    expected [FFT_POINTS];
    int          inCredits;
    int          granted;
    int          received;
    int          returnCount;
    int          doneCount;
    int          errorCount;
    int          testCount;
    int          cycleCount;
    tagT         curTag;
    logic        sparseGrants;
    logic [31:0] lfsr;

    fftAccel fftAccel_i (
        .clk(clk), .rst(rst), .start(start), .inverse(inverse), .tag(tag),
        .inValid(inValid), .inData(inData), .outCredit(outCredit),
        .inCreditReturn(inCreditReturn), .outValid(outValid), .outData(outData),
        .outTag(outTag), .busy(busy), .done(done)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference values and random bits
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois form of x^32+x^22+x^2+x+1
    endfunction

    // impulse of amp at m gives (amp/16) * (-j)^(m*k/4) and its conjugate for the inverse
    function automatic cplxWordT impulseBin(input int m, input int k, input sampleT amp,
                                            input logic inv);
        sampleT s;
        int     q;
        s = amp >>> 4;
        q = (m * k / 4) % 4;
        if (inv)
            q = (4 - q) % 4;
        case (q)
            0:       return {16'sd0, s};
            1:       return {-s, 16'sd0};
            2:       return {16'sd0, -s};
            default: return {s, 16'sd0};
        endcase
    endfunction

    task automatic queueImpulse(input int m, input sampleT amp, input logic inv);
        for (int n = 0; n < FFT_POINTS; n++) begin
            inQueue.push_back((n == m) ? {16'sd0, amp} : 32'd0);
            expected[n] = impulseBin(m, n, amp, inv);
        end
    endtask

    task automatic queueConstant(input sampleT amp);
        for (int n = 0; n < FFT_POINTS; n++) begin
            inQueue.push_back({16'sd0, amp});
            expected[n] = (n == 0) ? {16'sd0, amp} : 32'd0;   // all energy in bin 0
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one job from start to done followed by a compare of all 16 bins
    ////////////////////////////////////////////////////////////////////////////

    task automatic runJob(input string name, input logic inv, input tagT jobTag);
        int errorsBefore;
        int rxSize;
        errorsBefore = errorCount;
        rxQueue.delete();
        returnCount = 0;
        doneCount   = 0;
        curTag      = jobTag;
        start       = 1'b1;
        inverse     = inv;
        tag         = jobTag;
        @(negedge clk);
        start = 1'b0;
        do @(negedge clk); while (!done);
        rxSize = rxQueue.size();
        assert (rxSize == FFT_POINTS) else begin
            errorCount++;
            $display("[FAIL] %0d ns: %s got %0d words before done", $time, name, rxSize);
        end
        @(negedge clk);
        assert (doneCount == 1) else begin
            errorCount++;
            $display("[FAIL] %0d ns: %s done pulsed %0d times", $time, name, doneCount);
        end
        assert (returnCount == FFT_POINTS) else begin
            errorCount++;
            $display("[FAIL] %0d ns: %s returned %0d input credits", $time, name, returnCount);
        end
        for (int k = 0; k < rxSize && k < FFT_POINTS; k++) begin
            assert (rxQueue[k] == expected[k]) else begin
                errorCount++;
                $display("[FAIL] %0d ns: %s bin %0d got %h expected %h",
                         $time, name, k, rxQueue[k], expected[k]);
            end
        end
        reportTest(name, errorsBefore);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // host model for both links
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : hostModel
        logic wantGrant;
        if (!rst) begin
            if (inCreditReturn) begin
                inCredits++;
                returnCount++;
            end
            if (inCredits > 0 && inQueue.size() > 0) begin
                inValid = 1'b1;                         // send as soon as a credit is held
                inData  = inQueue.pop_front();
                inCredits--;
            end else begin
                inValid = 1'b0;
            end

            // outstanding credits here equal the DUT count before this edge
            assert (!outValid || granted != received) else begin
                errorCount++;
                $display("[FAIL] %0d ns: outValid with no output credit", $time);
            end
            if (outValid) begin
                assert (outTag == curTag) else begin
                    errorCount++;
                    $display("[FAIL] %0d ns: outTag %h expected %h", $time, outTag, curTag);
                end
                rxQueue.push_back(outData);
                received++;
            end
            if (done)
                doneCount++;

            wantGrant = lfsr[0];
            lfsr      = stepLfsr(lfsr);
            if (sparseGrants) begin
                wantGrant = wantGrant & lfsr[0];        // one grant chance in four
                lfsr      = stepLfsr(lfsr);
            end
            if (wantGrant && (granted - received) < OUT_CREDIT_MAX) begin
                outCredit = 1'b1;
                granted++;
            end else begin
                outCredit = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // protocol properties
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            errorCount++;
            $display("done stayed high for more than one cycle");
        end

    assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else begin
            errorCount++;
            $display("busy still high while done pulsed");
        end

    assert property (@(posedge clk) disable iff (rst) outValid |-> busy)
        else begin
            errorCount++;
            $display("outValid raised outside a job");
        end

    assert property (@(posedge clk) disable iff (rst) inCredits <= IN_DEPTH)
        else begin
            errorCount++;
            $display("host input credits rose above %0d", IN_DEPTH);
        end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int errorsBefore;
        rst          = 1'b1;
        start        = 1'b0;
        inverse      = 1'b0;
        tag          = '0;
        inValid      = 1'b0;
        inData       = '0;
        outCredit    = 1'b0;
        inCredits    = IN_DEPTH;
        granted      = 0;
        received     = 0;
        returnCount  = 0;
        doneCount    = 0;
        errorCount   = 0;
        testCount    = 0;
        curTag       = '0;
        sparseGrants = 1'b0;
        lfsr         = 32'hcdf5;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        errorsBefore = errorCount;
        assert (!outValid && !busy && !done && !inCreditReturn) else begin
            errorCount++;
            $display("[FAIL] %0d ns: outputs not idle after reset", $time);
        end
        reportTest("after reset", errorsBefore);

        queueImpulse(0, 16'sd4096, 1'b0);
        runJob("impulse at 0, forward", 1'b0, 8'h11);
        queueImpulse(8, 16'sd4096, 1'b0);
        runJob("impulse at 8, forward", 1'b0, 8'h22);
        queueImpulse(4, 16'sd3200, 1'b0);
        runJob("impulse at 4, forward", 1'b0, 8'h33);
        queueImpulse(4, 16'sd3200, 1'b1);
        runJob("impulse at 4, inverse", 1'b1, 8'h44);
        queueConstant(16'sd1024);
        runJob("constant input", 1'b0, 8'h5a);

        sparseGrants = 1'b1;                            // unload now stalls often
        queueImpulse(8, -16'sd2048, 1'b0);
        runJob("output back-pressure", 1'b0, 8'ha5);

        $display("tests %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

/* src/fftAccel.sv */
module fftAccel
    import fftPkg::*;
    import hostPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     inverse,
    input  tagT      tag,
    input  logic     inValid,
    input  cplxWordT inData,
    input  logic     outCredit,
    output logic     inCreditReturn,
    output logic     outValid,
    output cplxWordT outData,
    output tagT      outTag,
    output logic     busy,
    output logic     done
);

    ctrlStateT phase;
    logic      pop;
    logic      send;
    logic      popReady;
    logic      sendReady;
    logic      lastStep;
    logic      isInverse;
    indexT     loadIndex;
    indexT     unloadIndex;
    indexT     indexA;
    indexT     indexB;
    indexT     ramIndexA;
    twIndexT   twIndex;
    twiddleT   twReal;
    twiddleT   twImag;
    cplxWordT  popData;
    cplxWordT  rdDataA;
    cplxWordT  rdDataB;
    cplxWordT  wrDataA;
    cplxWordT  wrDataB;
    sampleT    aOutReal;
    sampleT    aOutImag;
    sampleT    bOutReal;
    sampleT    bOutImag;
    tagT       jobTag;
    logic      computing;

    ////////////////////////////////////////////////////////////////////////////
    // RAM port muxing by phase
    ////////////////////////////////////////////////////////////////////////////

    assign computing = (phase == COMPUTE);

    always_comb begin
        case (phase)
            LOAD:    ramIndexA = {loadIndex[0], loadIndex[1], loadIndex[2], loadIndex[3]};
            UNLOAD:  ramIndexA = unloadIndex;            // natural order out
            default: ramIndexA = indexA;
        endcase
    end

    assign wrDataA = (phase == LOAD) ? popData : {aOutImag, aOutReal};
    assign wrDataB = {bOutImag, bOutReal};

    assign outValid = send;
    assign outData  = rdDataA;
    assign outTag   = jobTag;

    fftControl fftControl_i (
        .clk(clk), .rst(rst), .start(start), .inverse(inverse), .tag(tag),
        .popReady(popReady), .sendReady(sendReady), .lastStep(lastStep),
        .phase(phase), .pop(pop), .send(send), .isInverse(isInverse), .jobTag(jobTag),
        .loadIndex(loadIndex), .unloadIndex(unloadIndex), .busy(busy), .done(done)
    );

    addressGen addressGen_i (
        .clk(clk), .rst(rst), .phase(phase),
        .indexA(indexA), .indexB(indexB), .twIndex(twIndex), .lastStep(lastStep)
    );

    twiddleRom twiddleRom_i (
        .twIndex(twIndex), .isInverse(isInverse), .twReal(twReal), .twImag(twImag)
    );

    butterflyUnit butterflyUnit_i (
        .aReal(rdDataA[15:0]), .aImag(rdDataA[31:16]),
        .bReal(rdDataB[15:0]), .bImag(rdDataB[31:16]),
        .twReal(twReal), .twImag(twImag),
        .aOutReal(aOutReal), .aOutImag(aOutImag), .bOutReal(bOutReal), .bOutImag(bOutImag)
    );

    fftRam fftRam_i (
        .clk(clk), .rst(rst), .writeEn(pop | computing),
        .indexA(ramIndexA), .indexB(indexB), .wrDataA(wrDataA), .wrDataB(wrDataB),
        .writeB(computing), .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    sampleBuffers sampleBuffers_i (
        .clk(clk), .rst(rst), .inValid(inValid), .inData(inData), .pop(pop),
        .send(send), .outCredit(outCredit), .popData(popData), .popReady(popReady),
        .inCreditReturn(inCreditReturn), .sendReady(sendReady)
    );

endmodule

/* src/fftControl.sv */
module fftControl
    import fftPkg::*;
    import hostPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      inverse,
    input  tagT       tag,
    input  logic      popReady,
    input  logic      sendReady,
    input  logic      lastStep,
    output ctrlStateT phase,
    output logic      pop,
    output logic      send,
    output logic      isInverse,
    output tagT       jobTag,
    output indexT     loadIndex,
    output indexT     unloadIndex,
    output logic      busy,
    output logic      done
);

    localparam indexT LAST_INDEX = indexT'(FFT_POINTS - 1);

    ctrlStateT state;

    assign phase = state;
    assign pop   = (state == LOAD) && popReady;          // one word per cycle when available
    assign send  = (state == UNLOAD) && sendReady;       // only with an output credit
    assign busy  = (state == LOAD) || (state == COMPUTE) || (state == UNLOAD);
    assign done  = (state == DONE);

    ////////////////////////////////////////////////////////////////////////////
    // job FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            loadIndex   <= '0;
            unloadIndex <= '0;
            isInverse   <= 1'b0;
            jobTag      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= LOAD;
                        isInverse <= inverse;            // direction held for the whole job
                        jobTag    <= tag;
                    end
                end
                LOAD: begin
                    if (pop) begin
                        loadIndex <= loadIndex + 4'd1;   // wraps back to 0 after 16
                        if (loadIndex == LAST_INDEX)
                            state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    if (lastStep)
                        state <= UNLOAD;
                end
                UNLOAD: begin
                    if (send) begin
                        unloadIndex <= unloadIndex + 4'd1;
                        if (unloadIndex == LAST_INDEX)
                            state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;                       // DONE lasts one cycle
                end
            endcase
        end
    end

endmodule

/* src/sampleBuffers.sv */
module sampleBuffers
    import fftPkg::*;
    import hostPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  cplxWordT inData,
    input  logic     pop,
    input  logic     send,
    input  logic     outCredit,
    output cplxWordT popData,
    output logic     popReady,
    output logic     inCreditReturn,
    output logic     sendReady
);

    localparam int PTR_BITS = $clog2(IN_DEPTH);

    cplxWordT              fifoMem [IN_DEPTH];
    logic [PTR_BITS-1:0]   wrPtr;
    logic [PTR_BITS-1:0]   rdPtr;
    creditT                fillCount;
    creditT                outCount;               // output credits held by the accelerator
    logic                  grant;

    ////////////////////////////////////////////////////////////////////////////
    // input FIFO without a full flag since the host never exceeds its credits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (inValid)
            fifoMem[wrPtr] <= inData;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wrPtr          <= '0;
            rdPtr          <= '0;
            fillCount      <= '0;
            inCreditReturn <= 1'b0;
        end else begin
            if (inValid)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            fillCount      <= fillCount + creditT'(inValid) - creditT'(pop);
            inCreditReturn <= pop;                       // one credit back per word taken
        end
    end

    assign popData  = fifoMem[rdPtr];
    assign popReady = (fillCount != '0);

    ////////////////////////////////////////////////////////////////////////////
    // output credit counter
    ////////////////////////////////////////////////////////////////////////////

    // a grant past the limit is dropped unless a send frees a slot
    assign grant = outCredit && ((outCount != creditT'(OUT_CREDIT_MAX)) || send);

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            outCount <= '0;
        else
            outCount <= outCount + creditT'(grant) - creditT'(send);
    end

    assign sendReady = (outCount != '0);

endmodule

/* src/fftRam.sv */
module fftRam
    import fftPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     writeEn,
    input  indexT    indexA,
    input  indexT    indexB,
    input  cplxWordT wrDataA,
    input  cplxWordT wrDataB,
    input  logic     writeB,
    output cplxWordT rdDataA,
    output cplxWordT rdDataB
);

    cplxWordT mem [FFT_POINTS];                          // in-place sample store

    // combinational reads feed the butterfly and the output link
    assign rdDataA = mem[indexA];
    assign rdDataB = mem[indexB];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < FFT_POINTS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (writeEn)
                mem[indexA] <= wrDataA;
            if (writeEn && writeB)
                mem[indexB] <= wrDataB;                  // second port only while computing
        end
    end

endmodule

/* src/addressGen.sv */
module addressGen
    import fftPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  ctrlStateT phase,
    output indexT     indexA,
    output indexT     indexB,
    output twIndexT   twIndex,
    output logic      lastStep
);

    logic [2:0] bflyCount;                               // butterfly within stage
    stageT      stage;
    indexT      span;                                    // 2 ** stage
    indexT      lowMask;                                 // position bits inside a group
    indexT      bflyWide;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bflyCount <= '0;
            stage     <= '0;
        end else if (phase == COMPUTE) begin
            bflyCount <= bflyCount + 3'd1;
            if (bflyCount == 3'(BFLY_PER_STAGE - 1))
                stage <= stage + 2'd1;                   // wraps to 0 after last stage
        end else begin
            bflyCount <= '0;
            stage     <= '0;
        end
    end

    // decimation-in-time pair with group bits moved up by one and the span bit selecting B
    always_comb begin
        span     = indexT'(1) << stage;
        lowMask  = span - indexT'(1);
        bflyWide = {1'b0, bflyCount};
        indexA   = ((bflyWide & ~lowMask) << 1) | (bflyWide & lowMask);
        indexB   = indexA | span;
        twIndex  = twIndexT'(bflyWide & lowMask) << (2'd3 - stage);
    end

    assign lastStep = (phase == COMPUTE) && (stage == stageT'(FFT_STAGES - 1))
                      && (bflyCount == 3'(BFLY_PER_STAGE - 1));

endmodule

/* src/butterflyUnit.sv */
module butterflyUnit
    import fftPkg::*;
(
    input  sampleT  aReal,
    input  sampleT  aImag,
    input  sampleT  bReal,
    input  sampleT  bImag,
    input  twiddleT twReal,
    input  twiddleT twImag,
    output sampleT  aOutReal,
    output sampleT  aOutImag,
    output sampleT  bOutReal,
    output sampleT  bOutImag
);

    logic signed [32:0] prodReal;                        // Re(W*B) before scaling
    logic signed [32:0] prodImag;                        // Im(W*B) before scaling
    logic signed [32:0] wbReal;
    logic signed [32:0] wbImag;
    logic signed [32:0] sumReal;
    logic signed [32:0] sumImag;
    logic signed [32:0] difReal;
    logic signed [32:0] difImag;

    ////////////////////////////////////////////////////////////////////////////
    // complex multiply W*B at full width
    ////////////////////////////////////////////////////////////////////////////

    assign prodReal = bReal * twReal - bImag * twImag;
    assign prodImag = bReal * twImag + bImag * twReal;

    assign wbReal = prodReal >>> TW_FRAC_BITS;           // back to sample scale
    assign wbImag = prodImag >>> TW_FRAC_BITS;

    ////////////////////////////////////////////////////////////////////////////
    // halved add and subtract so 4 stages scale by 1/16
    ////////////////////////////////////////////////////////////////////////////

    assign sumReal = aReal + wbReal;
    assign sumImag = aImag + wbImag;
    assign difReal = aReal - wbReal;
    assign difImag = aImag - wbImag;

    assign aOutReal = sumReal[16:1];                     // arithmetic shift right by one
    assign aOutImag = sumImag[16:1];
    assign bOutReal = difReal[16:1];
    assign bOutImag = difImag[16:1];

endmodule

/* src/twiddleRom.sv */
module twiddleRom
    import fftPkg::*;
(
    input  twIndexT twIndex,
    input  logic    isInverse,
    output twiddleT twReal,
    output twiddleT twImag
);

    twiddleT romImag;                                    // -sin for the forward transform

    // cos(2*pi*k/16) and -sin(2*pi*k/16) in Q2.14
    always_comb begin
        case (twIndex)
            3'd0:    {twReal, romImag} = { 16'sd16384,      16'sd0};
            3'd1:    {twReal, romImag} = { 16'sd15137,  -16'sd6270};
            3'd2:    {twReal, romImag} = { 16'sd11585, -16'sd11585};
            3'd3:    {twReal, romImag} = {  16'sd6270, -16'sd15137};
            3'd4:    {twReal, romImag} = {     16'sd0, -16'sd16384};
            3'd5:    {twReal, romImag} = { -16'sd6270, -16'sd15137};
            3'd6:    {twReal, romImag} = {-16'sd11585, -16'sd11585};
            default: {twReal, romImag} = {-16'sd15137,  -16'sd6270};
        endcase
    end

    assign twImag = isInverse ? -romImag : romImag;      // conjugate for the inverse

endmodule

/* src/hostPkg.sv */
package hostPkg;

    ////////////////////////////////////////////////////////////////////////////
    // host link
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] tagT;                            // job tag echoed on output

    localparam int IN_DEPTH = 4;                         // input FIFO depth = initial credits

    typedef logic [2:0] creditT;                         // credit / fill count

    localparam int OUT_CREDIT_MAX = 4;                   // most output credits outstanding

endpackage

/* src/fftPkg.sv */
package fftPkg;

    ////////////////////////////////////////////////////////////////////////////
    // transform size
    ////////////////////////////////////////////////////////////////////////////

    localparam int FFT_POINTS     = 16;                  // samples per job
    localparam int FFT_STAGES     = 4;                   // log2 of the size
    localparam int BFLY_PER_STAGE = 8;                   // butterflies in one stage
    localparam int TW_FRAC_BITS   = 14;                  // Q2.14 twiddles

    ////////////////////////////////////////////////////////////////////////////
    // numeric types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [15:0] sampleT;                 // one real or imag part
    typedef logic [31:0] cplxWordT;                      // {imag, real}
    typedef logic signed [15:0] twiddleT;                // 1.0 is 16384
    typedef logic [3:0] indexT;                          // RAM index
    typedef logic [2:0] twIndexT;                        // twiddle table index
    typedef logic [1:0] stageT;                          // stage number

    // job phases seen by control, address generator and top
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMPUTE,
        UNLOAD,
        DONE
    } ctrlStateT;

endpackage
